//--- bench/sample_generator_assertions.sv
`timescale 1ns/1ps

module sample_generator_assertions
	import dac_gen_pkg::*;
(
	input logic                      clk,
	input logic                      rst,
	input logic [FULL_CMD_WIDTH-1:0] ps_cmd,
	input logic                      valid_ps_cmd,
	input logic                      dac_rdy,
	input logic [BS_WIDTH-1:0]       dac_bs,
	input logic [BATCH_WIDTH-1:0]    dac_batch,
	input logic                      valid_dac_batch
);

	int                     fail_count = 0;
	logic                   cmd_seen;
	logic                   halted;
	logic                   mode_rand;
	logic                   mode_tri;
	logic                   have_prev;
	logic [BS_WIDTH-1:0]    sent_cnt;
	logic [BATCH_WIDTH-1:0] seed_q;
	logic [BATCH_WIDTH-1:0] prev_batch;
	logic                   run_cmd;
	logic                   halt_cmd;

	assign run_cmd  = valid_ps_cmd && (ps_cmd[CMD_TRI_BIT] || ps_cmd[CMD_RAND_BIT]);
	assign halt_cmd = valid_ps_cmd && ps_cmd[CMD_HALT_BIT];

	// seeds on the first batch, one galois step per lane afterwards
	function automatic logic [BATCH_WIDTH-1:0] rand_expect(
		input logic                   stepped,
		input logic [BATCH_WIDTH-1:0] from
	);
		logic [BATCH_WIDTH-1:0]  res;
		logic [SAMPLE_WIDTH-1:0] s;
		for (int i = 0; i < BATCH_SIZE; i++) begin
			s = from[i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
			if (!stepped) begin
				if (s == '0) begin
					s = LFSR_ZERO_SEED;
				end
			end else if (s[0]) begin
				s = (s >> 1) ^ LFSR_TAPS;
			end else begin
				s = s >> 1;
			end
			res[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = s;
		end
		return res;
	endfunction

	// neighbours one apart, one direction, nothing above the peak
	function automatic logic tri_ok(input logic [BATCH_WIDTH-1:0] b);
		logic                    up;
		logic                    down;
		logic [SAMPLE_WIDTH-1:0] a;
		logic [SAMPLE_WIDTH-1:0] n;
		up   = 1'b1;
		down = 1'b1;
		for (int i = 0; i < BATCH_SIZE - 1; i++) begin
			a = b[i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
			n = b[(i+1)*SAMPLE_WIDTH +: SAMPLE_WIDTH];
			if (n != a + SAMPLE_WIDTH'(1)) begin
				up = 1'b0;
			end
			if (n != a - SAMPLE_WIDTH'(1)) begin
				down = 1'b0;
			end
		end
		for (int i = 0; i < BATCH_SIZE; i++) begin
			if (b[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] > TRI_PEAK) begin
				return 1'b0;
			end
		end
		return up || down;
	endfunction

	// ========================================================================
	// reference state
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_seen  <= 1'b0;
			halted    <= 1'b0;
			mode_rand <= 1'b0;
			mode_tri  <= 1'b0;
			have_prev <= 1'b0;
			sent_cnt  <= '0;
		end else begin
			if (valid_ps_cmd) begin
				cmd_seen <= 1'b1;
			end
			if (halt_cmd) begin
				halted <= 1'b1;
			end else if (run_cmd) begin
				halted <= 1'b0;
			end
			if (run_cmd) begin
				mode_rand <= ps_cmd[CMD_RAND_BIT];
				mode_tri  <= ps_cmd[CMD_TRI_BIT] && !ps_cmd[CMD_RAND_BIT];
				have_prev <= 1'b0;
				sent_cnt  <= '0;
				seed_q    <= ps_cmd[CMD_WIDTH +: BATCH_WIDTH];
			end else if (valid_dac_batch) begin
				have_prev  <= 1'b1;
				sent_cnt   <= sent_cnt + BS_WIDTH'(1);
				prev_batch <= dac_batch;
			end
		end
	end

	// ========================================================================
	// checks
	// ========================================================================
	a_quiet_before_cmd: assert property (@(posedge clk) disable iff (rst)
		!cmd_seen |-> !valid_dac_batch)
	else begin
		$error("valid batch before the first command");
		fail_count++;
	end

	a_valid_needs_rdy: assert property (@(posedge clk) disable iff (rst)
		valid_dac_batch |-> dac_rdy)
	else begin
		$error("valid batch while the DAC is not ready");
		fail_count++;
	end

	a_tri_shape: assert property (@(posedge clk) disable iff (rst)
		(valid_dac_batch && mode_tri) |-> tri_ok(dac_batch))
	else begin
		$error("triangle batch %h has the wrong shape", dac_batch);
		fail_count++;
	end

	a_rand_seq: assert property (@(posedge clk) disable iff (rst)
		(valid_dac_batch && mode_rand)
		|-> dac_batch == rand_expect(have_prev, have_prev ? prev_batch : seed_q))
	else begin
		$error("random batch %h breaks the lane sequence", dac_batch);
		fail_count++;
	end

	a_burst_limit: assert property (@(posedge clk) disable iff (rst)
		(dac_bs != '0 && sent_cnt >= dac_bs) |-> !valid_dac_batch)
	else begin
		$error("batch delivered beyond the burst size %0d", dac_bs);
		fail_count++;
	end

	a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
		halted |-> !valid_dac_batch)
	else begin
		$error("valid batch after a halt command");
		fail_count++;
	end

endmodule

bind sample_generator sample_generator_assertions assertions_i (.*);

//--- bench/sample_generator_tb.sv
`timescale 1ns/1ps

module sample_generator_tb
	import dac_gen_pkg::*;
();

	// the phases take about 1700 cycles
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int RUN_CYCLES     = 600;

	localparam logic [CMD_WIDTH-1:0] TRI_CMD  = 3'b001;
	localparam logic [CMD_WIDTH-1:0] RAND_CMD = 3'b010;
	localparam logic [CMD_WIDTH-1:0] HALT_CMD = 3'b100;

	logic                      clk;
	logic                      rst;
	logic [FULL_CMD_WIDTH-1:0] ps_cmd;
	logic                      valid_ps_cmd;
	logic                      dac_rdy;
	logic [BS_WIDTH-1:0]       dac_bs;
	logic [BATCH_WIDTH-1:0]    dac_batch;
	logic                      valid_dac_batch;
	int                        fails_seen = 0;
	int                        timeouts = 0;

	sample_generator dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// DAC ready about three cycles in four
	initial begin
		void'($urandom(32'h080f_63da));
		dac_rdy = 1'b0;
		forever begin
			@(posedge clk);
			dac_rdy <= ($urandom % 4) != 0;
		end
	end

	task automatic send_cmd(
		input logic [CMD_WIDTH-1:0]   ctrl,
		input logic [BATCH_WIDTH-1:0] seeds,
		input logic [BS_WIDTH-1:0]    burst
	);
		@(posedge clk);
		ps_cmd       <= {seeds, ctrl};
		valid_ps_cmd <= 1'b1;
		dac_bs       <= burst;
		@(posedge clk);
		ps_cmd       <= '0;
		valid_ps_cmd <= 1'b0;
	endtask

	// halt state rises, then falls once the pipe tail is empty
	task automatic wait_drain();
		do begin
			@(negedge clk);
		end while (!dut_i.halt_state);
		do begin
			@(negedge clk);
		end while (dut_i.halt_state);
	endtask

	task automatic report_and_finish();
		$display("summary: %0d assertion failures, %0d timeouts",
			dut_i.assertions_i.fail_count, timeouts);
		if (dut_i.assertions_i.fail_count == 0 && timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	always @(negedge clk) begin
		if (dut_i.assertions_i.fail_count != fails_seen) begin
			fails_seen = dut_i.assertions_i.fail_count;
			$display("ERROR at %0t: assertion failure, %0d so far", $time, fails_seen);
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		timeouts = 1;
		report_and_finish();
	end

	initial begin
		rst          = 1'b1;
		ps_cmd       = '0;
		valid_ps_cmd = 1'b0;
		dac_bs       = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		repeat (20) @(posedge clk);

		// ====================================================================
		// free triangle, then random with one zero lane seed
		// ====================================================================
		send_cmd(TRI_CMD, '0, '0);
		repeat (RUN_CYCLES) @(posedge clk);
		send_cmd(HALT_CMD, '0, '0);
		wait_drain();
		send_cmd(RAND_CMD, {16'h0000, 16'hACE1, 16'h1234, 16'hBEEF}, '0);
		repeat (RUN_CYCLES) @(posedge clk);
		send_cmd(HALT_CMD, '0, '0);
		wait_drain();

		// ====================================================================
		// burst of 7, mid-run halt, restart
		// ====================================================================
		send_cmd(TRI_CMD, '0, 16'd7);
		wait_drain();
		repeat (40) @(posedge clk);
		send_cmd(RAND_CMD, {16'h8001, 16'h0F0F, 16'h0000, 16'h5A5A}, '0);
		repeat (RUN_CYCLES / 2) @(posedge clk);
		send_cmd(HALT_CMD, '0, '0);
		wait_drain();
		send_cmd(TRI_CMD, '0, 16'd12);
		wait_drain();
		repeat (20) @(posedge clk);
		report_and_finish();
	end

endmodule

//--- rtl/batch_pipe.sv
`timescale 1ns/1ps

module batch_pipe
	import dac_gen_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   advance,
	input  logic                   in_valid,
	input  logic [BATCH_WIDTH-1:0] in_batch,
	output logic                   tail_valid,
	output logic [BATCH_WIDTH-1:0] tail_batch
);

	logic [DAC_STAGES-1:0]  valid_q;
	logic [BATCH_WIDTH-1:0] batch_q [DAC_STAGES];

	// ========================================================================
	// valid bits
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else if (advance) begin
			valid_q <= {valid_q[DAC_STAGES-2:0], in_valid};
		end
	end

	// ========================================================================
	// payload
	// ========================================================================
	// holds still while the DAC stalls
	always_ff @(posedge clk) begin
		if (advance) begin
			batch_q[0] <= in_batch;
			for (int i = 1; i < DAC_STAGES; i++) begin
				batch_q[i] <= batch_q[i-1];
			end
		end
	end

	assign tail_valid = valid_q[DAC_STAGES-1];
	assign tail_batch = batch_q[DAC_STAGES-1];

endmodule

//--- rtl/burst_halt.sv
`timescale 1ns/1ps

module burst_halt
	import dac_gen_pkg::*;
(
	input  logic                clk,
	input  logic                rst,
	input  logic                ps_halt,
	input  logic                delivered,
	input  logic                tail_valid,
	input  logic [BS_WIDTH-1:0] dac_bs,
	output logic                halt_state
);

	typedef enum logic {IDLE, HALT} state_t;

	state_t              state;
	logic [BS_WIDTH-1:0] burst_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			burst_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (ps_halt) begin
						state <= HALT;
					end else if (delivered && dac_bs != '0) begin
						// last batch of the burst
						if (burst_cnt == dac_bs - BS_WIDTH'(1)) begin
							state <= HALT;
						end
						burst_cnt <= burst_cnt + BS_WIDTH'(1);
					end
				end
				HALT: begin
					// wait for the pipe tail to empty
					if (!tail_valid) begin
						state     <= IDLE;
						burst_cnt <= '0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign halt_state = (state == HALT);

endmodule

//--- rtl/dac_gen_pkg.sv
package dac_gen_pkg;

	// ========================================================================
	// sizes
	// ========================================================================
	localparam int SAMPLE_WIDTH   = 16;
	localparam int BATCH_SIZE     = 4;
	localparam int BATCH_WIDTH    = SAMPLE_WIDTH * BATCH_SIZE;
	localparam int CMD_WIDTH      = 3;
	localparam int FULL_CMD_WIDTH = CMD_WIDTH + BATCH_WIDTH;
	localparam int BS_WIDTH       = 16;
	localparam int DAC_STAGES     = 5;

	// ========================================================================
	// command layout
	// ========================================================================
	// seed field sits directly above the control bits
	localparam int CMD_TRI_BIT  = 0;
	localparam int CMD_RAND_BIT = 1;
	localparam int CMD_HALT_BIT = 2;

	// ========================================================================
	// source constants
	// ========================================================================
	// galois feedback mask, maximal length for 16 bits
	localparam logic [SAMPLE_WIDTH-1:0] LFSR_TAPS = 16'hB400;

	// all-zero state locks the register
	localparam logic [SAMPLE_WIDTH-1:0] LFSR_ZERO_SEED = 16'd1;

	// multiple of BATCH_SIZE so the base lands on it exactly
	localparam logic [SAMPLE_WIDTH-1:0] TRI_PEAK = 16'hFFF0;

endpackage

//--- rtl/gen_cmd_regs.sv
`timescale 1ns/1ps

module gen_cmd_regs
	import dac_gen_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic [FULL_CMD_WIDTH-1:0] ps_cmd,
	input  logic                      valid_ps_cmd,
	input  logic                      halt,
	output logic                      run_rand,
	output logic                      run_tri,
	output logic                      set_seeds,
	output logic                      ps_halt,
	output logic [BATCH_WIDTH-1:0]    rand_seed
);

	logic [CMD_WIDTH-1:0]   cmd_ctrl;
	logic [BATCH_WIDTH-1:0] cmd_seed;
	logic                   seed_cmd;

	assign cmd_ctrl = ps_cmd[CMD_WIDTH-1:0];
	assign cmd_seed = ps_cmd[CMD_WIDTH +: BATCH_WIDTH];
	assign seed_cmd = valid_ps_cmd && cmd_ctrl[CMD_RAND_BIT];

	// ========================================================================
	// control flags
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst || halt) begin
			run_tri  <= 1'b0;
			run_rand <= 1'b0;
			ps_halt  <= 1'b0;
		end else if (valid_ps_cmd) begin
			run_tri  <= cmd_ctrl[CMD_TRI_BIT];
			run_rand <= cmd_ctrl[CMD_RAND_BIT];
			ps_halt  <= cmd_ctrl[CMD_HALT_BIT];
		end
	end

	// ========================================================================
	// seeds
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst || halt) begin
			rand_seed <= '0;
		end else if (seed_cmd) begin
			rand_seed <= cmd_seed;
		end
	end

	// one cycle, lines up with the new rand_seed
	always_ff @(posedge clk) begin
		if (rst || halt) begin
			set_seeds <= 1'b0;
		end else begin
			set_seeds <= seed_cmd;
		end
	end

endmodule

//--- rtl/lfsr_lane.sv
`timescale 1ns/1ps

module lfsr_lane
	import dac_gen_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic [SAMPLE_WIDTH-1:0] seed,
	input  logic                    run,
	output logic [SAMPLE_WIDTH-1:0] sample_out
);

	logic [SAMPLE_WIDTH-1:0] state;
	logic [SAMPLE_WIDTH-1:0] state_next;

	// right shift, taps folded in when a one drops out
	always_comb begin
		if (state[0]) begin
			state_next = (state >> 1) ^ LFSR_TAPS;
		end else begin
			state_next = state >> 1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= (seed == '0) ? LFSR_ZERO_SEED : seed;
		end else if (run) begin
			state <= state_next;
		end
	end

	assign sample_out = state;

endmodule

//--- rtl/sample_generator.sv
`timescale 1ns/1ps

module sample_generator
	import dac_gen_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic [FULL_CMD_WIDTH-1:0] ps_cmd,
	input  logic                      valid_ps_cmd,
	input  logic                      dac_rdy,
	input  logic [BS_WIDTH-1:0]       dac_bs,
	output logic [BATCH_WIDTH-1:0]    dac_batch,
	output logic                      valid_dac_batch
);

	logic                   run_rand;
	logic                   run_tri;
	logic                   set_seeds;
	logic                   ps_halt;
	logic                   halt_state;
	logic                   halt;
	logic                   src_rst;
	logic                   out_en;
	logic [BATCH_WIDTH-1:0] rand_seed;
	logic [BATCH_WIDTH-1:0] rand_batch;
	logic [BATCH_WIDTH-1:0] tri_batch;
	logic                   pipe_valid;
	logic [BATCH_WIDTH-1:0] pipe_batch;
	logic                   tail_valid;
	logic [BATCH_WIDTH-1:0] tail_batch;

	assign halt    = ps_halt || halt_state;
	assign src_rst = rst || set_seeds || halt;

	gen_cmd_regs cmd_regs_i (
		.clk         (clk),
		.rst         (rst),
		.ps_cmd      (ps_cmd),
		.valid_ps_cmd(valid_ps_cmd),
		.halt        (halt),
		.run_rand    (run_rand),
		.run_tri     (run_tri),
		.set_seeds   (set_seeds),
		.ps_halt     (ps_halt),
		.rand_seed   (rand_seed)
	);

	// ========================================================================
	// sources
	// ========================================================================
	for (genvar i = 0; i < BATCH_SIZE; i++) begin : g_lfsr
		lfsr_lane lfsr_i (
			.clk       (clk),
			.rst       (src_rst),
			.seed      (rand_seed[i*SAMPLE_WIDTH +: SAMPLE_WIDTH]),
			.run       (run_rand && dac_rdy),
			.sample_out(rand_batch[i*SAMPLE_WIDTH +: SAMPLE_WIDTH])
		);
	end

	triangle_batch tri_i (
		.clk      (clk),
		.rst      (src_rst),
		.run      (run_tri && dac_rdy),
		.batch_out(tri_batch)
	);

	// random wins if both flags are set
	always_comb begin
		pipe_valid = 1'b0;
		pipe_batch = '0;
		if (!set_seeds && !halt) begin
			if (run_rand) begin
				pipe_valid = 1'b1;
				pipe_batch = rand_batch;
			end else if (run_tri) begin
				pipe_valid = 1'b1;
				pipe_batch = tri_batch;
			end
		end
	end

	// ========================================================================
	// output pipe and burst control
	// ========================================================================
	batch_pipe pipe_i (
		.clk       (clk),
		.rst       (rst),
		.advance   (dac_rdy),
		.in_valid  (pipe_valid),
		.in_batch  (pipe_batch),
		.tail_valid(tail_valid),
		.tail_batch(tail_batch)
	);

	burst_halt burst_i (
		.clk       (clk),
		.rst       (rst),
		.ps_halt   (ps_halt),
		.delivered (valid_dac_batch),
		.tail_valid(tail_valid),
		.dac_bs    (dac_bs),
		.halt_state(halt_state)
	);

	// batches still draining during a halt are dropped here
	assign out_en          = tail_valid && dac_rdy && !halt;
	assign valid_dac_batch = out_en;
	assign dac_batch       = out_en ? tail_batch : '0;

endmodule

//--- rtl/triangle_batch.sv
`timescale 1ns/1ps

module triangle_batch
	import dac_gen_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   run,
	output logic [BATCH_WIDTH-1:0] batch_out
);

	logic [SAMPLE_WIDTH-1:0] base;
	logic                    rising;

	// base walks by a full batch per advance
	// turning points chosen so no lane leaves [0, TRI_PEAK]
	always_ff @(posedge clk) begin
		if (rst) begin
			base   <= '0;
			rising <= 1'b1;
		end else if (run) begin
			if (rising) begin
				if (base == TRI_PEAK - SAMPLE_WIDTH'(BATCH_SIZE)) begin
					base   <= TRI_PEAK;
					rising <= 1'b0;
				end else begin
					base <= base + SAMPLE_WIDTH'(BATCH_SIZE);
				end
			end else begin
				if (base == SAMPLE_WIDTH'(BATCH_SIZE)) begin
					base   <= '0;
					rising <= 1'b1;
				end else begin
					base <= base - SAMPLE_WIDTH'(BATCH_SIZE);
				end
			end
		end
	end

	// lane i is i steps away from base in the current direction
	for (genvar i = 0; i < BATCH_SIZE; i++) begin : g_lane
		assign batch_out[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = rising
			? base + SAMPLE_WIDTH'(i)
			: base - SAMPLE_WIDTH'(i);
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the sample generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sample_generator_tb \
	-f sample_generator.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vsample_generator_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sample_generator.f
rtl/dac_gen_pkg.sv
rtl/lfsr_lane.sv
rtl/triangle_batch.sv
rtl/gen_cmd_regs.sv
rtl/batch_pipe.sv
rtl/burst_halt.sv
rtl/sample_generator.sv
bench/sample_generator_assertions.sv
bench/sample_generator_tb.sv
